// ==== tb.f ====
motorPkg.sv
pwmPkg.sv
motorCommutator.sv
pwmGenerator.sv
phaseDriver.sv
gateProtect.sv
bldcDriveTop.sv
bldcDrive_properties.sv
tbBldc.sv

// ==== tbBldc.sv ====
`timescale 1ns/10ps

module tbBldc;
    import motorPkg::*;
    import pwmPkg::*;

    localparam int stepCycles = 600;
    localparam int deadCycles = 4;
    localparam int stepLimit  = stepCycles + 20;   // timeout for any wait on a step

    logic                 clk;
    logic                 nRst;
    logic                 run;
    logic                 dir;
    dutyT                 duty;
    logic                 overCurrent;
    logic                 faultClear;
    logic [numPhases-1:0] gateHigh;
    logic [numPhases-1:0] gateLow;
    logic                 fault;
    stepIdxT              step;

    int          errors   = 0;
    int          checks   = 0;
    int          testsRun = 0;
    logic [31:0] rndState = 32'hd94105cf;

    bldcDriveTop #(
        .stepCycles(stepCycles),
        .deadCycles(deadCycles)
    ) u_dut (
        .clk(clk),
        .nRst(nRst),
        .run(run),
        .dir(dir),
        .duty(duty),
        .overCurrent(overCurrent),
        .faultClear(faultClear),
        .gateHigh(gateHigh),
        .gateLow(gateLow),
        .fault(fault),
        .step(step)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic bit gatesFollowTable();
        return (gateHigh == stepHigh(step)) && (gateLow == stepLow(step));
    endfunction

    function automatic bit gatesOff();
        return (gateHigh == '0) && (gateLow == '0);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic flagFailure(input string what);
        errors++;
        $display("failure: %s", what);
    endtask

    task automatic logTestResult(input string name, input int errBefore);
        testsRun++;
        if (errors == errBefore) $display("%s: ok", name);
        else $display("%s: failed with %0d errors", name, errors - errBefore);
    endtask

    // follow the current step to its end, gates and length checked when full is set
    task automatic runStep(input bit full);
        stepIdxT cur;
        int      cnt;
        cur = step;
        cnt = 0;
        while (step == cur && cnt < stepLimit) begin
            @(negedge clk);
            cnt++;
            if (full && step == cur && cnt >= 10) begin   // past the dead-time window
                checkValue("gateHigh", gateHigh, stepHigh(cur));
                checkValue("gateLow", gateLow, stepLow(cur));
            end
        end
        if (step == cur) flagFailure("step did not change in time");
        else if (full) checkValue("step length", cnt, stepCycles);
    endtask

    // time the high-gate pulses of the active phase over one step
    task automatic measurePulses(input dutyT d);
        stepIdxT cur;
        logic    level;
        logic    last;
        int      cnt;
        int      riseAt;
        int      fallAt;
        int      pulses;
        cur    = step;
        last   = |(gateHigh & stepHigh(cur));
        cnt    = 0;
        riseAt = -1;
        fallAt = -1;
        pulses = 0;
        while (step == cur && cnt < stepLimit) begin
            @(negedge clk);
            cnt++;
            level = |(gateHigh & stepHigh(cur));
            if (step == cur) begin
                if (d == dutyFullOff && cnt >= 3) checkValue("gateHigh", gateHigh, 0);
                if (level && !last) begin
                    if (fallAt >= 0) begin
                        checkValue("off gap", cnt - fallAt, pwmPeriod - d + deadCycles);
                    end
                    riseAt = cnt;
                end
                if (!level && last) begin
                    if (riseAt >= 0) begin
                        checkValue("on pulse", cnt - riseAt, d - deadCycles);
                        pulses++;
                    end
                    fallAt = cnt;
                end
                last = level;
            end
        end
        if (step == cur) flagFailure("step did not end while timing pulses");
        if (d != dutyFullOff && pulses == 0) flagFailure("no complete high pulse in a step");
    endtask

    task automatic settleGates(input int limit, input string what);
        int cnt;
        cnt = 0;
        while (!gatesFollowTable() && cnt < limit) begin
            @(negedge clk);
            cnt++;
        end
        if (!gatesFollowTable()) flagFailure({"gates do not follow the table ", what});
    endtask

    task automatic waitStopped(input string what);
        int cnt;
        cnt = 0;
        while (!(step == '0 && gatesOff()) && cnt < 5) begin
            @(negedge clk);
            cnt++;
        end
        if (!(step == '0 && gatesOff())) flagFailure({"drive not stopped ", what});
    endtask

    task automatic testIdle();
        int errBefore;
        errBefore = errors;
        for (int i = 0; i < 1000; i++) begin
            @(negedge clk);
            checkValue("gateHigh", gateHigh, 0);
            checkValue("gateLow", gateLow, 0);
            checkValue("fault", fault, 0);
            checkValue("step", step, 0);
        end
        logTestResult("reset and idle", errBefore);
    endtask

    task automatic testForward();
        int errBefore;
        errBefore = errors;
        duty = dutyFullOn;
        dir  = 1'b0;
        @(negedge clk);   // let the idle reload latch full duty
        run = 1'b1;
        for (int s = 0; s < numSteps; s++) begin
            checkValue("step", step, s);
            runStep(1'b1);
        end
        checkValue("step", step, 0);
        logTestResult("forward commutation", errBefore);
    endtask

    task automatic testDuty();
        int   errBefore;
        dutyT d;
        errBefore = errors;
        for (int i = 0; i < 5; i++) begin
            rndState = nextRandom(rndState);
            d        = (i == 4) ? dutyFullOff : dutyT'(20 + rndState % 181);
            duty     = d;
            runStep(1'b0);   // duty is picked up at this step end
            measurePulses(d);
        end
        logTestResult("pwm duty", errBefore);
    endtask

    task automatic testReverse();
        int errBefore;
        errBefore = errors;
        run  = 1'b0;
        dir  = 1'b1;
        duty = dutyFullOn;
        waitStopped("before reverse");
        @(negedge clk);
        run = 1'b1;
        for (int s = 0; s < numSteps; s++) begin
            checkValue("step", step, (numSteps - s) % numSteps);
            runStep(1'b1);
        end
        checkValue("step", step, 0);
        logTestResult("reverse commutation", errBefore);
    endtask

    task automatic testFault();
        int errBefore;
        int cnt;
        errBefore = errors;
        settleGates(20, "before the fault");
        overCurrent = 1'b1;
        cnt = 0;
        while (!(fault && gatesOff()) && cnt < 3) begin
            @(negedge clk);
            cnt++;
        end
        if (!(fault && gatesOff())) flagFailure("fault not raised within 3 cycles");
        faultClear = 1'b1;   // overcurrent still present
        @(negedge clk);
        faultClear = 1'b0;
        checkValue("fault", fault, 1);
        checkValue("gateHigh", gateHigh, 0);
        overCurrent = 1'b0;
        @(negedge clk);
        checkValue("fault", fault, 1);
        faultClear = 1'b1;
        @(negedge clk);
        faultClear = 1'b0;
        checkValue("fault", fault, 0);
        settleGates(10, "after the fault clears");
        logTestResult("fault", errBefore);
    endtask

    task automatic testStop();
        int errBefore;
        errBefore = errors;
        runStep(1'b0);   // move off step 0 first
        run = 1'b0;
        waitStopped("after run drops");
        checkValue("fault", fault, 0);
        logTestResult("stop", errBefore);
    endtask

    initial begin
        nRst        = 1'b0;
        run         = 1'b0;
        dir         = 1'b0;
        duty        = dutyFullOff;
        overCurrent = 1'b0;
        faultClear  = 1'b0;
        repeat (2) @(negedge clk);
        nRst = 1'b1;
        testIdle();
        testForward();
        testDuty();
        testReverse();
        testFault();
        testStop();
        errors += u_dut.u_props.assertFails;
        $display("tests: %0d, checks: %0d, errors: %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== bldcDrive_properties.sv ====
`timescale 1ns/10ps

module bldcDriveProperties (
    input logic                           clk,
    input logic                           nRst,
    input logic [motorPkg::numPhases-1:0] gateHigh,
    input logic [motorPkg::numPhases-1:0] gateLow,
    input logic                           fault,
    input logic                           stepLast
);

    int assertFails = 0;   // failed assertion count

    // both switches of one phase never on together
    noShootThrough: assert property (@(posedge clk) disable iff (!nRst)
        (gateHigh & gateLow) == '0)
        else begin
            assertFails++;
            $error("shoot-through on gates, high %0h low %0h", gateHigh, gateLow);
        end

    gatesOffInFault: assert property (@(posedge clk) disable iff (!nRst)
        fault |-> (gateHigh == '0 && gateLow == '0))
        else begin
            assertFails++;
            $error("gate on while fault is set, high %0h low %0h", gateHigh, gateLow);
        end

    // step strobe lasts a single cycle
    singleStepStrobe: assert property (@(posedge clk) disable iff (!nRst)
        stepLast |=> !stepLast)
        else begin
            assertFails++;
            $error("stepLast high for two cycles in a row");
        end

endmodule

bind bldcDriveTop bldcDriveProperties u_props (
    .clk(clk),
    .nRst(nRst),
    .gateHigh(gateHigh),
    .gateLow(gateLow),
    .fault(fault),
    .stepLast(stepLast)
);

// ==== bldcDriveTop.sv ====
`timescale 1ns/10ps

module bldcDriveTop #(
    parameter int stepCycles = 600,
    parameter int deadCycles = 4
) (
    input  logic                           clk,
    input  logic                           nRst,
    input  logic                           run,
    input  logic                           dir,
    input  pwmPkg::dutyT                   duty,
    input  logic                           overCurrent,
    input  logic                           faultClear,
    output logic [motorPkg::numPhases-1:0] gateHigh,
    output logic [motorPkg::numPhases-1:0] gateLow,
    output logic                           fault,
    output motorPkg::stepIdxT              step
);
    import motorPkg::*;

    logic                 stepLast;
    logic                 pwm;
    logic [numPhases-1:0] highEn;
    logic [numPhases-1:0] lowEn;
    logic [numPhases-1:0] phaseEn;
    logic [numPhases-1:0] reqHigh;
    logic [numPhases-1:0] reqLow;

    motorCommutator #(
        .stepCycles(stepCycles)
    ) u_commutator (
        .clk(clk),
        .nRst(nRst),
        .run(run),
        .dir(dir),
        .step(step),
        .stepLast(stepLast),
        .highEn(highEn),
        .lowEn(lowEn),
        .phaseEn(phaseEn)
    );

    pwmGenerator u_pwm (
        .clk(clk),
        .nRst(nRst),
        .duty(duty),
        .stepLast(stepLast),
        .phaseEn(phaseEn),
        .pwm(pwm)
    );

    // one driver per phase, all share the PWM
    for (genvar i = 0; i < numPhases; i++) begin : phaseGen
        phaseDriver #(
            .deadCycles(deadCycles)
        ) u_phase (
            .clk(clk),
            .nRst(nRst),
            .highEn(highEn[i]),
            .lowEn(lowEn[i]),
            .pwm(pwm),
            .reqHigh(reqHigh[i]),
            .reqLow(reqLow[i])
        );
    end

    gateProtect u_protect (
        .clk(clk),
        .nRst(nRst),
        .reqHigh(reqHigh),
        .reqLow(reqLow),
        .overCurrent(overCurrent),
        .faultClear(faultClear),
        .gateHigh(gateHigh),
        .gateLow(gateLow),
        .fault(fault)
    );

endmodule

// ==== gateProtect.sv ====
`timescale 1ns/10ps

module gateProtect (
    input  logic                           clk,
    input  logic                           nRst,
    input  logic [motorPkg::numPhases-1:0] reqHigh,
    input  logic [motorPkg::numPhases-1:0] reqLow,
    input  logic                           overCurrent,
    input  logic                           faultClear,
    output logic [motorPkg::numPhases-1:0] gateHigh,
    output logic [motorPkg::numPhases-1:0] gateLow,
    output logic                           fault
);

    logic shootThrough;
    logic faultNext;

    // any phase asking for both switches at once
    assign shootThrough = |(reqHigh & reqLow);

    // clear only takes when the overcurrent is gone
    assign faultNext = overCurrent || shootThrough || (fault && !faultClear);

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            fault    <= 1'b0;
            gateHigh <= '0;
            gateLow  <= '0;
        end else begin
            fault <= faultNext;
            if (faultNext) begin
                gateHigh <= '0;   // off in the same cycle fault rises
                gateLow  <= '0;
            end else begin
                gateHigh <= reqHigh;
                gateLow  <= reqLow;
            end
        end
    end

endmodule

// ==== phaseDriver.sv ====
`timescale 1ns/10ps

module phaseDriver #(
    parameter int deadCycles = 4
) (
    input  logic clk,
    input  logic nRst,
    input  logic highEn,
    input  logic lowEn,
    input  logic pwm,
    output logic reqHigh,
    output logic reqLow
);

    localparam int cntW = ($clog2(deadCycles + 1) < 1) ? 1 : $clog2(deadCycles + 1);
    localparam logic [cntW-1:0] deadLast = cntW'(deadCycles);

    logic [cntW-1:0] deadCnt;
    logic            wantHigh;
    logic            wantLow;
    logic            bothOff;
    logic            deadDone;

    assign wantHigh = highEn && pwm;   // high side chopped by the PWM
    assign wantLow  = lowEn;
    assign bothOff  = !reqHigh && !reqLow;
    assign deadDone = (deadCnt == deadLast);

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            reqHigh <= 1'b0;
            reqLow  <= 1'b0;
            deadCnt <= '0;
        end else begin
            // a side already on stays on while wanted, turn-off is immediate
            reqHigh <= wantHigh && (reqHigh || (bothOff && deadDone));
            // high side wins if both are asked for at once
            reqLow  <= wantLow && (reqLow || (bothOff && deadDone && !wantHigh));

            // count off cycles while a turn-on is pending
            if (!bothOff || !(wantHigh || wantLow)) begin
                deadCnt <= '0;
            end else if (!deadDone) begin
                deadCnt <= deadCnt + 1'b1;
            end
        end
    end

endmodule

// ==== pwmGenerator.sv ====
`timescale 1ns/10ps

module pwmGenerator (
    input  logic         clk,
    input  logic         nRst,
    input  pwmPkg::dutyT duty,
    input  logic         stepLast,
    input  logic [2:0]   phaseEn,
    output logic         pwm
);
    import pwmPkg::*;

    dutyT dutyHold;     // duty copy used between reloads
    dutyT pwmCnt;       // cycles left in the current on or off phase
    dutyT onLoad;
    dutyT offLoad;
    dutyT reloadOff;    // off time computed from the incoming duty
    logic reload;
    logic cntLast;

    // restart at each step end and while the bridge is idle
    assign reload = stepLast || (phaseEn == '0);

    assign cntLast   = (pwmCnt <= dutyT'(1));
    assign onLoad    = dutyHold;
    assign offLoad   = dutyT'(pwmPeriod) - dutyHold;
    assign reloadOff = dutyT'(pwmPeriod) - duty;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            dutyHold <= dutyFullOff;
            pwmCnt   <= dutyT'(pwmPeriod);
            pwm      <= 1'b0;
        end else if (reload) begin
            // latch new duty and start with the off phase
            dutyHold <= duty;
            pwmCnt   <= reloadOff;
            pwm      <= (duty == dutyFullOn);
        end else if (dutyHold == dutyFullOn) begin
            pwm <= 1'b1;    // always on, counter idles
        end else if (dutyHold == dutyFullOff) begin
            pwm <= 1'b0;    // always off
        end else if (cntLast) begin
            if (pwm) begin
                pwmCnt <= offLoad;
            end else begin
                pwmCnt <= onLoad;
            end
            pwm <= ~pwm;
        end else begin
            pwmCnt <= pwmCnt - 1'b1;
        end
    end

endmodule

// ==== motorCommutator.sv ====
`timescale 1ns/10ps

module motorCommutator #(
    parameter int stepCycles = 600
) (
    input  logic                           clk,
    input  logic                           nRst,
    input  logic                           run,
    input  logic                           dir,      // 1 walks the table backwards
    output motorPkg::stepIdxT              step,
    output logic                           stepLast,
    output logic [motorPkg::numPhases-1:0] highEn,
    output logic [motorPkg::numPhases-1:0] lowEn,
    output logic [motorPkg::numPhases-1:0] phaseEn
);
    import motorPkg::*;

    localparam int cntW = (stepCycles > 1) ? $clog2(stepCycles) : 1;
    localparam logic [cntW-1:0] cntLast = cntW'(stepCycles - 1);
    localparam stepIdxT stepMax = stepIdxT'(numSteps - 1);

    logic [cntW-1:0] stepCnt;
    stepIdxT         stepNext;

    // strobe on the final count of a step
    assign stepLast = run && (stepCnt == cntLast);

    // wrap around the six-step table in either direction
    always_comb begin
        if (dir) begin
            if (step == '0) begin
                stepNext = stepMax;
            end else begin
                stepNext = step - 1'b1;
            end
        end else begin
            if (step == stepMax) begin
                stepNext = '0;
            end else begin
                stepNext = step + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            stepCnt <= '0;
            step    <= '0;
        end else if (!run) begin
            stepCnt <= '0;   // parked at the start of step 0
            step    <= '0;
        end else if (stepCnt == cntLast) begin
            stepCnt <= '0;
            step    <= stepNext;
        end else begin
            stepCnt <= stepCnt + 1'b1;
        end
    end

    // enables follow the table lookup, all off while stopped
    always_comb begin
        if (run) begin
            highEn = stepHigh(step);
            lowEn  = stepLow(step);
        end else begin
            highEn = '0;
            lowEn  = '0;
        end
    end

    assign phaseEn = highEn | lowEn;   // floating phase stays 0

endmodule

// ==== pwmPkg.sv ====
package pwmPkg;

    localparam int dutyW = 8;

    typedef logic [dutyW-1:0] dutyT;

    // on time plus off time, in clk cycles
    localparam int pwmPeriod = 255;

    // special codes, no counting for these
    localparam dutyT dutyFullOn  = dutyT'(255);
    localparam dutyT dutyFullOff = dutyT'(0);

endpackage

// ==== motorPkg.sv ====
package motorPkg;

    localparam int numPhases = 3;
    localparam int numSteps  = 6;
    localparam int stepIdxW  = 3;

    typedef logic [stepIdxW-1:0]  stepIdxT;
    typedef logic [numPhases-1:0] phaseMaskT;   // bit 0 = A, bit 1 = B, bit 2 = C

    // phase driven high in each step
    function automatic phaseMaskT stepHigh(stepIdxT s);
        case (s)
            3'd0, 3'd1: return 3'b001;
            3'd2, 3'd3: return 3'b010;
            3'd4, 3'd5: return 3'b100;
            default:    return 3'b000;
        endcase
    endfunction

    // phase pulled low in each step
    function automatic phaseMaskT stepLow(stepIdxT s);
        case (s)
            3'd0, 3'd5: return 3'b010;
            3'd1, 3'd2: return 3'b100;
            3'd3, 3'd4: return 3'b001;
            default:    return 3'b000;
        endcase
    endfunction

endpackage
